/* rtl/line_follower_pkg.sv */
package line_follower_pkg;

	// ADC result width and one converted sample
	localparam int SAMPLE_W = 12;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// Serial ADC channel address
	typedef logic [2:0] channel_t;

	// Reflectance sensors on the ADC inputs
	localparam channel_t LEFT_CH   = 3'd5;
	localparam channel_t CENTRE_CH = 3'd6;
	localparam channel_t RIGHT_CH  = 3'd7;

	// Bits are left, centre, right with left as MSB; 1 is black
	typedef logic [2:0] pattern_t;

	// Case number on the display, pattern plus one
	typedef logic [3:0] digit_t;

	// PWM counters and duty values
	localparam int PWM_CNT_W = 16;

	typedef logic [PWM_CNT_W-1:0] pwm_count_t;

	// Drive decision taken from a confirmed pattern
	typedef enum logic [1:0]
	{
		STOP,
		FORWARD,
		PIVOT_LEFT,
		PIVOT_RIGHT
	} drive_action_t;

endpackage

/* rtl/adc_serial_reader.sv */
`timescale 1ns/100ps

module adc_serial_reader
	import line_follower_pkg::*;
#(
	parameter int ADC_CLK_DIV = 20
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     adc_data,
	output logic     adc_clk,
	output logic     adc_chip_select,
	output logic     adc_address,
	output sample_t  sample,
	output channel_t sample_channel,
	output logic     sample_valid
);

	localparam int HALF_DIV = ADC_CLK_DIV / 2;
	localparam int DIV_W = $clog2(ADC_CLK_DIV);

	logic [DIV_W-1:0] div_cnt;
	logic             rise_tick;
	logic             fall_tick;
	logic [3:0]       period;
	logic [3:0]       next_period;
	channel_t         next_ch;
	channel_t         cur_ch;
	logic             first_frame;
	sample_t          shift_reg;

	// Last clk cycle of the low and of the high half
	assign rise_tick = (div_cnt == DIV_W'(HALF_DIV - 1));
	assign fall_tick = (div_cnt == DIV_W'(ADC_CLK_DIV - 1));
	assign next_period = period + 4'd1;

	function automatic channel_t rotate_channel(input channel_t ch);
		case (ch)
			LEFT_CH:   return CENTRE_CH;
			CENTRE_CH: return RIGHT_CH;
			default:   return LEFT_CH;
		endcase
	endfunction

	// ADC clock divider
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			div_cnt <= '0;
			adc_clk <= 1'b0;
		end
		else
		begin
			if (fall_tick)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;

			if (rise_tick)
				adc_clk <= 1'b1;
			else if (fall_tick)
				adc_clk <= 1'b0;
		end
	end

	// Converter is selected as soon as reset is released
	always_ff @(posedge clk)
	begin
		if (rst)
			adc_chip_select <= 1'b1;
		else
			adc_chip_select <= 1'b0;
	end

	// Frame sequencing, address bits and channel rotation
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			period       <= 4'd0;
			adc_address  <= 1'b0;
			next_ch      <= LEFT_CH;
			cur_ch       <= LEFT_CH;
			first_frame  <= 1'b1;
			sample_valid <= 1'b0;
		end
		else
		begin
			sample_valid <= 1'b0;
			if (fall_tick)
			begin
				period <= next_period;

				// Address goes out MSB first in periods 2 to 4
				case (next_period)
					4'd2:    adc_address <= next_ch[2];
					4'd3:    adc_address <= next_ch[1];
					4'd4:    adc_address <= next_ch[0];
					default: adc_address <= 1'b0;
				endcase

				if (period == 4'd15)
				begin
					sample_valid <= !first_frame;
					first_frame  <= 1'b0;
					cur_ch       <= next_ch;
					next_ch      <= rotate_channel(next_ch);
				end
			end
		end
	end

	// Data bits arrive in periods 4 to 15
	always_ff @(posedge clk)
	begin
		if (rise_tick && period >= 4'd4)
			shift_reg <= {shift_reg[SAMPLE_W-2:0], adc_data};

		if (fall_tick && period == 4'd15)
		begin
			sample         <= shift_reg;
			sample_channel <= cur_ch;
		end
	end

endmodule

/* rtl/sensor_classifier.sv */
`timescale 1ns/100ps

module sensor_classifier
	import line_follower_pkg::*;
#(
	parameter int WHITE_THRESHOLD = 1600
)
(
	input  logic     clk,
	input  logic     rst,
	input  sample_t  sample,
	input  channel_t sample_channel,
	input  logic     sample_valid,
	output pattern_t pattern,
	output logic     led_l,
	output logic     led_m,
	output logic     led_r
);

	localparam sample_t THRESHOLD = sample_t'(WHITE_THRESHOLD);

	logic black;

	// Values at the threshold still count as white
	assign black = (sample > THRESHOLD);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pattern <= '0;
			led_l   <= 1'b0;
			led_m   <= 1'b0;
			led_r   <= 1'b0;
		end
		else if (sample_valid)
		begin
			// LED lights when its sensor sees white
			case (sample_channel)
				LEFT_CH:
				begin
					pattern[2] <= black;
					led_l      <= !black;
				end
				CENTRE_CH:
				begin
					pattern[1] <= black;
					led_m      <= !black;
				end
				RIGHT_CH:
				begin
					pattern[0] <= black;
					led_r      <= !black;
				end
				default:
				begin
					pattern <= pattern;
				end
			endcase
		end
	end

endmodule

/* rtl/pattern_debouncer.sv */
`timescale 1ns/100ps

module pattern_debouncer
	import line_follower_pkg::*;
#(
	parameter int CONFIRM_CYCLES = 50
)
(
	input  logic     clk,
	input  logic     rst,
	input  pattern_t pattern,
	input  logic     busy,
	output logic     confirm,
	output pattern_t confirmed_pattern
);

	localparam int CNT_W = $clog2(CONFIRM_CYCLES + 1);

	pattern_t   prev_pattern;
	logic [CNT_W-1:0] stable_cnt;
	logic       stable_done;

	// This cycle would make CONFIRM_CYCLES steady idle cycles
	assign stable_done = (stable_cnt == CNT_W'(CONFIRM_CYCLES - 1));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prev_pattern <= '0;
			stable_cnt   <= '0;
			confirm      <= 1'b0;
		end
		else
		begin
			prev_pattern <= pattern;
			confirm      <= 1'b0;

			if (busy)
			begin
				// No counting while the wheels run
				stable_cnt <= '0;
			end
			else if (pattern != prev_pattern)
			begin
				stable_cnt <= '0;
			end
			else if (stable_done)
			begin
				stable_cnt <= '0;
				confirm    <= 1'b1;
			end
			else
			begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

	// Pattern travels with the confirm pulse
	always_ff @(posedge clk)
	begin
		if (rst)
			confirmed_pattern <= '0;
		else if (!busy && pattern == prev_pattern && stable_done)
			confirmed_pattern <= pattern;
	end

endmodule

/* rtl/motor_pwm_driver.sv */
`timescale 1ns/100ps

module motor_pwm_driver
	import line_follower_pkg::*;
#(
	parameter int PWM_PERIOD = 50000,
	parameter int FAST_DUTY  = 50000,
	parameter int SLOW_DUTY  = 50000
)
(
	input  logic     clk,
	input  logic     rst,
	input  logic     confirm,
	input  pattern_t confirmed_pattern,
	output logic     busy,
	output logic     rw_f,
	output logic     rw_b,
	output logic     lw_f,
	output logic     lw_b,
	output digit_t   digit
);

	localparam pwm_count_t LAST_CNT = pwm_count_t'(PWM_PERIOD - 1);
	localparam pwm_count_t FAST     = pwm_count_t'(FAST_DUTY);
	localparam pwm_count_t SLOW     = pwm_count_t'(SLOW_DUTY);

	drive_action_t next_action;
	drive_action_t action;
	pwm_count_t    pwm_cnt;
	pwm_count_t    rw_f_duty;
	pwm_count_t    rw_b_duty;
	pwm_count_t    lw_f_duty;
	pwm_count_t    lw_b_duty;

	// Pattern decode, left bit first
	always_comb
	begin
		case (confirmed_pattern)
			3'b010:         next_action = FORWARD;
			3'b001, 3'b011: next_action = PIVOT_RIGHT;
			3'b100, 3'b110: next_action = PIVOT_LEFT;
			default:        next_action = STOP;
		endcase
	end

	// Run control and digit display
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy    <= 1'b0;
			action  <= STOP;
			pwm_cnt <= '0;
			digit   <= '0;
		end
		else if (!busy)
		begin
			pwm_cnt <= '0;
			if (confirm)
			begin
				busy   <= 1'b1;
				action <= next_action;
				digit  <= {1'b0, confirmed_pattern} + digit_t'(1);
			end
		end
		else if (action == STOP || pwm_cnt == LAST_CNT)
		begin
			busy    <= 1'b0;
			pwm_cnt <= '0;
			digit   <= '0;
		end
		else
		begin
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	// Duty latch, wheels not named by the action stay at zero
	always_ff @(posedge clk)
	begin
		if (!busy && confirm)
		begin
			rw_f_duty <= '0;
			rw_b_duty <= '0;
			lw_f_duty <= '0;
			lw_b_duty <= '0;
			case (next_action)
				FORWARD:
				begin
					rw_f_duty <= FAST;
					lw_f_duty <= FAST;
				end
				PIVOT_RIGHT:
				begin
					lw_f_duty <= FAST;
					rw_b_duty <= SLOW;
				end
				PIVOT_LEFT:
				begin
					rw_f_duty <= FAST;
					lw_b_duty <= SLOW;
				end
				default:
				begin
					rw_f_duty <= '0;
				end
			endcase
		end
	end

	// Active high for the first duty cycles of the period
	assign rw_f = busy && (pwm_cnt < rw_f_duty);
	assign rw_b = busy && (pwm_cnt < rw_b_duty);
	assign lw_f = busy && (pwm_cnt < lw_f_duty);
	assign lw_b = busy && (pwm_cnt < lw_b_duty);

endmodule

/* rtl/line_follower.sv */
`timescale 1ns/100ps

module line_follower
	import line_follower_pkg::*;
#(
	parameter int ADC_CLK_DIV     = 20,
	parameter int WHITE_THRESHOLD = 1600,
	parameter int CONFIRM_CYCLES  = 50,
	parameter int PWM_PERIOD      = 50000,
	parameter int FAST_DUTY       = 50000,
	parameter int SLOW_DUTY       = 50000
)
(
	input  logic   clk,
	input  logic   rst,
	output logic   adc_clk,
	output logic   adc_chip_select,
	output logic   adc_address,
	input  logic   adc_data,
	output logic   rw_f,
	output logic   rw_b,
	output logic   lw_f,
	output logic   lw_b,
	output logic   led_l,
	output logic   led_m,
	output logic   led_r,
	output digit_t digit
);

	sample_t  sample;
	channel_t sample_channel;
	logic     sample_valid;
	pattern_t pattern;
	logic     busy;
	logic     confirm;
	pattern_t confirmed_pattern;

	adc_serial_reader #(
		.ADC_CLK_DIV(ADC_CLK_DIV)
	) i_adc_serial_reader (
		.clk(clk),
		.rst(rst),
		.adc_data(adc_data),
		.adc_clk(adc_clk),
		.adc_chip_select(adc_chip_select),
		.adc_address(adc_address),
		.sample(sample),
		.sample_channel(sample_channel),
		.sample_valid(sample_valid)
	);

	sensor_classifier #(
		.WHITE_THRESHOLD(WHITE_THRESHOLD)
	) i_sensor_classifier (
		.clk(clk),
		.rst(rst),
		.sample(sample),
		.sample_channel(sample_channel),
		.sample_valid(sample_valid),
		.pattern(pattern),
		.led_l(led_l),
		.led_m(led_m),
		.led_r(led_r)
	);

	pattern_debouncer #(
		.CONFIRM_CYCLES(CONFIRM_CYCLES)
	) i_pattern_debouncer (
		.clk(clk),
		.rst(rst),
		.pattern(pattern),
		.busy(busy),
		.confirm(confirm),
		.confirmed_pattern(confirmed_pattern)
	);

	motor_pwm_driver #(
		.PWM_PERIOD(PWM_PERIOD),
		.FAST_DUTY(FAST_DUTY),
		.SLOW_DUTY(SLOW_DUTY)
	) i_motor_pwm_driver (
		.clk(clk),
		.rst(rst),
		.confirm(confirm),
		.confirmed_pattern(confirmed_pattern),
		.busy(busy),
		.rw_f(rw_f),
		.rw_b(rw_b),
		.lw_f(lw_f),
		.lw_b(lw_b),
		.digit(digit)
	);

endmodule

/* test/line_follower_adc_model.sv */
`timescale 1ns/100ps

module line_follower_adc_model
	import line_follower_pkg::*;
(
	input  logic    adc_clk,
	input  logic    adc_chip_select,
	input  logic    adc_address,
	input  sample_t left_value,
	input  sample_t centre_value,
	input  sample_t right_value,
	output logic    adc_data
);

	logic [3:0] period;
	channel_t   addr_shift;
	channel_t   conv_ch;
	sample_t    word;
	logic       data_on;
	logic [3:0] bit_idx;

	function automatic sample_t value_for(input channel_t ch);
		case (ch)
			LEFT_CH:   return left_value;
			CENTRE_CH: return centre_value;
			RIGHT_CH:  return right_value;
			default:   return '0;
		endcase
	endfunction

	// Period count and address bits, both taken on the rising edge
	always @(posedge adc_clk or posedge adc_chip_select)
	begin
		if (adc_chip_select)
		begin
			period     <= 4'd0;
			addr_shift <= '0;
		end
		else
		begin
			if (period >= 4'd2 && period <= 4'd4)
				addr_shift <= {addr_shift[1:0], adc_address};
			period <= period + 4'd1;
		end
	end

	// Counter already points at the period that starts on this falling edge
	always @(negedge adc_clk or posedge adc_chip_select)
	begin
		if (adc_chip_select)
		begin
			conv_ch <= '0;
			word    <= '0;
			data_on <= 1'b0;
			bit_idx <= 4'd0;
		end
		else
		begin
			// New frame converts the channel addressed in the last one
			if (period == 4'd0)
				conv_ch <= addr_shift;
			if (period == 4'd4)
				word <= value_for(conv_ch);
			data_on <= (period >= 4'd4);
			bit_idx <= 4'd15 - period;
		end
	end

	assign adc_data = data_on ? word[bit_idx] : 1'b0;

endmodule

/* test/tb_line_follower.sv */
`timescale 1ns/100ps

module tb_line_follower
	import line_follower_pkg::*;
();

	localparam int ADC_CLK_DIV     = 4;
	localparam int WHITE_THRESHOLD = 1600;
	localparam int CONFIRM_CYCLES  = 50;
	localparam int PWM_PERIOD      = 200;
	localparam int FAST_DUTY       = 150;
	localparam int SLOW_DUTY       = 60;
	localparam int NUM_ROWS        = 10;
	localparam int TIMEOUT_CYCLES  = NUM_ROWS * 4000;

	typedef struct packed
	{
		sample_t    left;
		sample_t    centre;
		sample_t    right;
		logic [2:0] leds;
		int         digit;
		int         rw_f;
		int         rw_b;
		int         lw_f;
		int         lw_b;
		int         run;
	} row_t;

	logic    clk;
	logic    rst;
	logic    adc_clk;
	logic    adc_chip_select;
	logic    adc_address;
	logic    adc_data;
	logic    rw_f;
	logic    rw_b;
	logic    lw_f;
	logic    lw_b;
	logic    led_l;
	logic    led_m;
	logic    led_r;
	digit_t  digit;
	sample_t left_value;
	sample_t centre_value;
	sample_t right_value;
	row_t    rows[NUM_ROWS];
	int      seed;
	int      seed_ret;
	int      error_count = 0;
	int      check_count = 0;
	int      cycle_count = 0;

	line_follower #(
		.ADC_CLK_DIV(ADC_CLK_DIV),
		.WHITE_THRESHOLD(WHITE_THRESHOLD),
		.CONFIRM_CYCLES(CONFIRM_CYCLES),
		.PWM_PERIOD(PWM_PERIOD),
		.FAST_DUTY(FAST_DUTY),
		.SLOW_DUTY(SLOW_DUTY)
	) i_line_follower (
		.clk(clk),
		.rst(rst),
		.adc_clk(adc_clk),
		.adc_chip_select(adc_chip_select),
		.adc_address(adc_address),
		.adc_data(adc_data),
		.rw_f(rw_f),
		.rw_b(rw_b),
		.lw_f(lw_f),
		.lw_b(lw_b),
		.led_l(led_l),
		.led_m(led_m),
		.led_r(led_r),
		.digit(digit)
	);

	line_follower_adc_model i_line_follower_adc_model (
		.adc_clk(adc_clk),
		.adc_chip_select(adc_chip_select),
		.adc_address(adc_address),
		.left_value(left_value),
		.centre_value(centre_value),
		.right_value(right_value),
		.adc_data(adc_data)
	);

	always #2 clk = ~clk;

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input int expected, input int actual);
		check_count++;
		if (expected !== actual)
		begin
			error_count++;
			$display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
		end
	endtask

	// High and low halves of the converter clock in clk cycles
	task automatic check_adc_clock();
		int high_cycles;
		int low_cycles;
		high_cycles = 0;
		low_cycles  = 0;
		@(posedge adc_clk);
		@(negedge clk);
		while (adc_clk)
		begin
			high_cycles++;
			@(negedge clk);
		end
		while (!adc_clk)
		begin
			low_cycles++;
			@(negedge clk);
		end
		check_value("adc_clk high cycles", ADC_CLK_DIV / 2, high_cycles);
		check_value("adc_clk low cycles", ADC_CLK_DIV / 2, low_cycles);
	endtask

	function automatic sample_t white_value();
		return sample_t'($urandom_range(WHITE_THRESHOLD, 0));
	endfunction

	function automatic sample_t black_value();
		return sample_t'($urandom_range(4095, WHITE_THRESHOLD + 1));
	endfunction

	task automatic add_row(input int idx, input sample_t l, input sample_t m, input sample_t r,
		input logic [2:0] leds, input int dig, input int rwf, input int rwb, input int lwf,
		input int lwb, input int run);
		row_t row;
		row.left   = l;
		row.centre = m;
		row.right  = r;
		row.leds   = leds;
		row.digit  = dig;
		row.rw_f   = rwf;
		row.rw_b   = rwb;
		row.lw_f   = lwf;
		row.lw_b   = lwb;
		row.run    = run;
		rows[idx]  = row;
	endtask

	// LEDs are l, m, r; wheel columns are rw_f, rw_b, lw_f, lw_b
	task automatic load_table();
		add_row(0, white_value(), white_value(), white_value(), 3'b111, 1, 0, 0, 0, 0, 1);
		add_row(1, white_value(), white_value(), black_value(), 3'b110, 2,
			0, SLOW_DUTY, FAST_DUTY, 0, PWM_PERIOD);
		add_row(2, white_value(), black_value(), white_value(), 3'b101, 3,
			FAST_DUTY, 0, FAST_DUTY, 0, PWM_PERIOD);
		add_row(3, white_value(), black_value(), black_value(), 3'b100, 4,
			0, SLOW_DUTY, FAST_DUTY, 0, PWM_PERIOD);
		add_row(4, black_value(), white_value(), white_value(), 3'b011, 5,
			FAST_DUTY, 0, 0, SLOW_DUTY, PWM_PERIOD);
		add_row(5, black_value(), white_value(), black_value(), 3'b010, 6, 0, 0, 0, 0, 1);
		add_row(6, black_value(), black_value(), white_value(), 3'b001, 7,
			FAST_DUTY, 0, 0, SLOW_DUTY, PWM_PERIOD);
		add_row(7, black_value(), black_value(), black_value(), 3'b000, 8, 0, 0, 0, 0, 1);
		// Threshold boundary, 1600 is white and 1601 is black
		add_row(8, 12'd1601, 12'd1600, 12'd1601, 3'b010, 6, 0, 0, 0, 0, 1);
		add_row(9, 12'd1600, 12'd1601, 12'd1600, 3'b101, 3,
			FAST_DUTY, 0, FAST_DUTY, 0, PWM_PERIOD);
	endtask

	task automatic run_row(input int idx);
		row_t   r;
		string  name;
		digit_t shown;
		int     run;
		int     gap;
		int     steady;
		int     rwf;
		int     rwb;
		int     lwf;
		int     lwb;
		r = rows[idx];
		name = $sformatf("row %0d", idx);
		@(posedge clk);
		left_value   <= r.left;
		centre_value <= r.centre;
		right_value  <= r.right;

		// Four frames cover a fresh conversion of all three channels
		repeat (4 * 16) @(posedge adc_clk);
		@(negedge clk);
		check_value({name, " led_l"}, r.leds[2], led_l);
		check_value({name, " led_m"}, r.leds[1], led_m);
		check_value({name, " led_r"}, r.leds[0], led_r);

		// A run that began before the pattern settled is left to finish
		while (digit != 0)
			@(negedge clk);
		while (digit == 0)
			@(negedge clk);
		shown  = digit;
		steady = 1;
		run    = 0;
		rwf    = 0;
		rwb    = 0;
		lwf    = 0;
		lwb    = 0;
		while (digit != 0)
		begin
			if (digit != shown)
				steady = 0;
			run++;
			rwf += rw_f;
			rwb += rw_b;
			lwf += lw_f;
			lwb += lw_b;
			@(negedge clk);
		end

		// Held pattern is confirmed again after the idle count
		gap = 0;
		while (digit == 0)
		begin
			gap++;
			@(negedge clk);
		end

		check_value({name, " digit"}, r.digit, shown);
		check_value({name, " digit steady"}, 1, steady);
		check_value({name, " run cycles"}, r.run, run);
		check_value({name, " rw_f high"}, r.rw_f, rwf);
		check_value({name, " rw_b high"}, r.rw_b, rwb);
		check_value({name, " lw_f high"}, r.lw_f, lwf);
		check_value({name, " lw_b high"}, r.lw_b, lwb);
		check_value({name, " idle gap"}, CONFIRM_CYCLES + 1, gap);
	endtask

	initial
	begin
		seed = 51122;
		seed_ret = $urandom(seed);
		clk = 1'b0;
		rst = 1'b1;
		left_value   = '0;
		centre_value = '0;
		right_value  = '0;
		load_table();

		repeat (7) @(posedge clk);
		@(negedge clk);
		check_value("chip select in reset", 1, adc_chip_select);
		check_value("adc_clk in reset", 0, adc_clk);
		check_value("adc_address in reset", 0, adc_address);
		@(posedge clk);
		rst <= 1'b0;
		// Chip select is registered and drops one cycle after release
		@(posedge clk);
		@(negedge clk);
		check_value("chip select after reset", 0, adc_chip_select);
		check_adc_clock();

		for (int i = 0; i < NUM_ROWS; i++)
			run_row(i);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* line_follower.f */
rtl/line_follower_pkg.sv
rtl/adc_serial_reader.sv
rtl/sensor_classifier.sv
rtl/pattern_debouncer.sv
rtl/motor_pwm_driver.sv
rtl/line_follower.sv
test/line_follower_adc_model.sv
test/tb_line_follower.sv
